//--- decode_stage.f
hdl/rv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/rvc_expander.sv
hdl/instr_decoder.sv
hdl/imm_extender.sv
hdl/reg_file.sv
hdl/branch_predictor.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  branch_cls_t br_cls_i,
    input  xlen_t       pc_i,
    input  xlen_t       rs1_data_i,
    input  xlen_t       imm_i,
    input  logic        rs1_dep_i,    // rs1 still in flight, jalr target unknown
    output xlen_t       redir_pc_o,
    output logic        taken_o
);

    xlen_t pc_target;
    xlen_t reg_target;

    assign pc_target  = pc_i + imm_i;
    assign reg_target = (rs1_data_i + imm_i) & ~xlen_t'(1);   // jalr clears bit 0

    // btfn: backward taken, forward not taken
    assign taken_o = br_cls_i.is_jal
                   | (br_cls_i.is_branch & imm_i[31])
                   | (br_cls_i.is_jalr & ~rs1_dep_i);

    assign redir_pc_o = br_cls_i.is_jalr ? reg_target : pc_target;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,         // also the flush
    input  logic     en_i,           // low = stall
    input  xlen_t    pc_i,           // address of this instruction
    input  instr_t   instr_i,
    input  logic     rd_wr_en_i,     // writeback port
    input  reg_idx_t rd_wr_idx_i,
    input  xlen_t    rd_wr_data_i,
    input  logic     rs1_dep_i,      // from hazard unit
    output id_ex_t   id_ex_o,
    output xlen_t    redir_pc_o,
    output logic     redir_taken_o
);

    // ==================================================
    // combinational decode path
    // ==================================================
    instr_t      exp_instr;
    instr_t      instr_sel;
    logic        is_compressed;
    logic        exp_illegal;
    logic        dec_illegal;
    ctrl_t       ctrl;
    imm_fmt_e    imm_fmt;
    branch_cls_t br_cls;
    xlen_t       imm;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    xlen_t       pred_pc;
    logic        pred_taken;
    xlen_t       link_pc;

    rvc_expander i_rvc_expander (
        .instr_i         (instr_i[15:0]),
        .instr_o         (exp_instr),
        .is_compressed_o (is_compressed),
        .illegal_o       (exp_illegal)
    );

    assign instr_sel = is_compressed ? exp_instr : instr_i;
    assign link_pc   = pc_i + (is_compressed ? xlen_t'(2) : xlen_t'(4));

    instr_decoder i_instr_decoder (
        .instr_i   (instr_sel),
        .ctrl_o    (ctrl),
        .imm_fmt_o (imm_fmt),
        .br_cls_o  (br_cls),
        .illegal_o (dec_illegal)
    );

    imm_extender i_imm_extender (
        .instr_i   (instr_sel),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_idx_i  (instr_sel[19:15]),
        .rs2_idx_i  (instr_sel[24:20]),
        .rd_idx_i   (rd_wr_idx_i),
        .rd_data_i  (rd_wr_data_i),
        .rd_wr_en_i (rd_wr_en_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    branch_predictor i_branch_predictor (
        .br_cls_i   (br_cls),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data),
        .imm_i      (imm),
        .rs1_dep_i  (rs1_dep_i),
        .redir_pc_o (pred_pc),
        .taken_o    (pred_taken)
    );

    // ==================================================
    // decode to execute register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_ex_o       <= '0;     // alu add, mem none, no write
            redir_pc_o    <= '0;
            redir_taken_o <= 1'b0;
        end else if (en_i) begin
            id_ex_o.ctrl     <= ctrl;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            id_ex_o.imm      <= imm;
            id_ex_o.link_pc  <= link_pc;
            id_ex_o.rd_idx   <= instr_sel[11:7];
            id_ex_o.illegal  <= exp_illegal | dec_illegal;
            redir_pc_o       <= pred_pc;
            redir_taken_o    <= pred_taken;
        end
    end

endmodule

//--- hdl/id_ctrl_pkg.sv
package id_ctrl_pkg;
    import rv_isa_pkg::*;

    // ==================================================
    // execute side encodings
    // ==================================================
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,    // reset value, keep at zero
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10    // lui, operand b straight through
    } alu_op_e;

    // none plus eight access kinds
    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_type_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_LINK   // jal / jalr return address
    } wb_src_e;

    // ==================================================
    // structs handed between blocks
    // ==================================================
    typedef struct packed {
        alu_op_e   alu_op;
        logic      op1_is_pc;      // operand a is pc, else rs1
        logic      op2_is_imm;     // operand b is imm, else rs2
        logic      is_beq_class;   // beq / bne
        logic      is_blt_class;   // blt, bge, bltu, bgeu
        mem_type_e mem_type;
        wb_src_e   wb_src;
        logic      wb_en;
    } ctrl_t;

    typedef struct packed {
        logic is_branch;
        logic is_jal;
        logic is_jalr;
    } branch_cls_t;

    // decode to execute packet
    typedef struct packed {
        ctrl_t    ctrl;
        xlen_t    rs1_data;
        xlen_t    rs2_data;
        xlen_t    imm;
        xlen_t    link_pc;
        reg_idx_t rd_idx;
        logic     illegal;
    } id_ex_t;

endpackage

//--- hdl/imm_extender.sv
`timescale 1ns/1ps

module imm_extender
    import rv_isa_pkg::*;
(
    input  instr_t   instr_i,
    input  imm_fmt_e imm_fmt_i,
    output xlen_t    imm_o
);

    logic sign;

    assign sign = instr_i[31];   // every format signs from bit 31

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instr_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;   // no immediate
        endcase
    end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  instr_t      instr_i,
    output ctrl_t       ctrl_o,
    output imm_fmt_e    imm_fmt_o,
    output branch_cls_t br_cls_o,
    output logic        illegal_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_shift;
    alu_op_e    f3_alu;     // alu op straight from funct3

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD:  f3_alu = ALU_ADD;
            F3_SLL:  f3_alu = ALU_SLL;
            F3_SLT:  f3_alu = ALU_SLT;
            F3_SLTU: f3_alu = ALU_SLTU;
            F3_XOR:  f3_alu = ALU_XOR;
            F3_SR:   f3_alu = ALU_SRL;
            F3_OR:   f3_alu = ALU_OR;
            default: f3_alu = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o    = '0;          // alu add, no mem, wb from alu, no write
        imm_fmt_o = IMM_NONE;
        br_cls_o  = '0;
        illegal_o = 1'b0;
        case (opcode)
            OP_LUI: begin
                ctrl_o.alu_op     = ALU_PASS_B;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.wb_en      = 1'b1;
                imm_fmt_o         = IMM_U;
            end
            OP_AUIPC, OP_JAL: begin   // both add imm to pc
                ctrl_o.op1_is_pc  = 1'b1;
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.wb_en      = 1'b1;
                ctrl_o.wb_src     = (opcode == OP_JAL) ? WB_PC_LINK : WB_ALU;
                imm_fmt_o         = (opcode == OP_JAL) ? IMM_J : IMM_U;
                br_cls_o.is_jal   = (opcode == OP_JAL);
            end
            OP_JALR: begin
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.wb_en      = 1'b1;
                ctrl_o.wb_src     = WB_PC_LINK;
                imm_fmt_o         = IMM_I;
                br_cls_o.is_jalr  = 1'b1;
                illegal_o         = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                imm_fmt_o          = IMM_B;
                br_cls_o.is_branch = 1'b1;
                ctrl_o.is_beq_class = (funct3[2:1] == 2'b00);
                ctrl_o.is_blt_class = funct3[2];
                ctrl_o.alu_op = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
                illegal_o     = (funct3[2:1] == 2'b01);   // 010, 011 unused
            end
            OP_LOAD: begin
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.wb_en      = 1'b1;
                ctrl_o.wb_src     = WB_MEM;
                imm_fmt_o         = IMM_I;
                case (funct3)
                    3'b000:  ctrl_o.mem_type = MEM_LB;
                    3'b001:  ctrl_o.mem_type = MEM_LH;
                    3'b010:  ctrl_o.mem_type = MEM_LW;
                    3'b100:  ctrl_o.mem_type = MEM_LBU;
                    3'b101:  ctrl_o.mem_type = MEM_LHU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_STORE: begin
                ctrl_o.op2_is_imm = 1'b1;
                imm_fmt_o         = IMM_S;
                case (funct3)
                    3'b000:  ctrl_o.mem_type = MEM_SB;
                    3'b001:  ctrl_o.mem_type = MEM_SH;
                    3'b010:  ctrl_o.mem_type = MEM_SW;
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_IMM: begin
                ctrl_o.op2_is_imm = 1'b1;
                ctrl_o.wb_en      = 1'b1;
                imm_fmt_o         = IMM_I;
                ctrl_o.alu_op = (funct3 == F3_SR && funct7 == F7_ALT) ? ALU_SRA : f3_alu;
                // shift immediates need a clean funct7
                illegal_o = is_shift && !(funct7 == F7_BASE ||
                                          (funct7 == F7_ALT && funct3 == F3_SR));
            end
            OP_REG: begin
                ctrl_o.wb_en  = 1'b1;
                ctrl_o.alu_op = (funct7 != F7_ALT) ? f3_alu :
                                (funct3 == F3_ADD) ? ALU_SUB : ALU_SRA;
                // funct7 0000001 is mul/div, not supported
                illegal_o = !(funct7 == F7_BASE ||
                              (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
            end
            default: illegal_o = 1'b1;   // csr, fence, fp, ...
        endcase
        if (illegal_o) begin  // no side effects, no redirect
            ctrl_o.wb_en    = 1'b0;
            ctrl_o.mem_type = MEM_NONE;
            br_cls_o        = '0;
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    input  reg_idx_t rd_idx_i,
    input  xlen_t    rd_data_i,
    input  logic     rd_wr_en_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    xlen_t regs [NUM_REGS];

    // x0 never written, so it reads zero after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr_en_i && rd_idx_i != '0) begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // reads see the old value during a write cycle
    assign rs1_data_o = regs[rs1_idx_i];
    assign rs2_data_o = regs[rs2_idx_i];

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ==================================================
    // field widths and base types
    // ==================================================
    localparam int XLEN     = 32;
    localparam int REG_W    = 5;   // register index width
    localparam int OPCODE_W = 7;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]     xlen_t;     // data or address word
    typedef logic [31:0]         instr_t;    // uncompressed instruction word
    typedef logic [REG_W-1:0]    reg_idx_t;
    typedef logic [OPCODE_W-1:0] opcode_t;

    // ==================================================
    // major opcodes, rv32i subset only
    // ==================================================
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // funct3 of the integer alu group
    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // srl and sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

    // immediate layouts
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

//--- hdl/rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander
    import rv_isa_pkg::*;
(
    input  logic [15:0] instr_i,
    output instr_t      instr_o,
    output logic        is_compressed_o,
    output logic        illegal_o
);

    logic [15:0] c;
    reg_idx_t    rd_p;       // rd' / rs2' in bits 4:2
    reg_idx_t    rs1_p;      // rs1' / rd' in bits 9:7
    logic [19:0] j_field;    // instr[31:12] of the jal form

    assign c     = instr_i;
    assign rd_p  = {2'b01, c[4:2]};   // x8..x15
    assign rs1_p = {2'b01, c[9:7]};
    // offset[11|4|9:8|10|6|7|3:1|5] rearranged into jal order
    assign j_field = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                      c[12], {8{c[12]}}};

    assign is_compressed_o = (c[1:0] != 2'b11);

    always_comb begin
        instr_o   = '0;
        illegal_o = 1'b0;
        case ({c[1:0], c[15:13]})
            // quadrant 0
            5'b00_000: begin  // c.addi4spn
                instr_o   = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, F3_ADD,
                             rd_p, OP_IMM};
                illegal_o = (c[12:5] == 8'd0);   // also catches the all-zero word
            end
            5'b00_010: instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p,
                                  OP_LOAD};                                  // c.lw
            5'b00_110: instr_o = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010, c[11:10], c[6],
                                  2'b00, OP_STORE};                          // c.sw
            // quadrant 1
            5'b01_000: instr_o = {{7{c[12]}}, c[6:2], c[11:7], F3_ADD, c[11:7], OP_IMM};
            5'b01_001: instr_o = {j_field, 5'd1, OP_JAL};                    // c.jal
            5'b01_010: instr_o = {{7{c[12]}}, c[6:2], 5'd0, F3_ADD, c[11:7], OP_IMM}; // c.li
            5'b01_011: begin
                if (c[11:7] == 5'd2) begin  // c.addi16sp
                    instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'd2, F3_ADD,
                               5'd2, OP_IMM};
                end else begin              // c.lui
                    instr_o = {{15{c[12]}}, c[6:2], c[11:7], OP_LUI};
                end
                illegal_o = ({c[12], c[6:2]} == 6'd0);  // zero imm reserved
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00: instr_o = {F7_BASE, c[6:2], rs1_p, F3_SR, rs1_p, OP_IMM}; // srli
                    2'b01: instr_o = {F7_ALT, c[6:2], rs1_p, F3_SR, rs1_p, OP_IMM};  // srai
                    2'b10: instr_o = {{7{c[12]}}, c[6:2], rs1_p, F3_AND, rs1_p, OP_IMM};
                    default: begin
                        case (c[6:5])
                            2'b00: instr_o = {F7_ALT, rd_p, rs1_p, F3_ADD, rs1_p, OP_REG};
                            2'b01: instr_o = {F7_BASE, rd_p, rs1_p, F3_XOR, rs1_p, OP_REG};
                            2'b10: instr_o = {F7_BASE, rd_p, rs1_p, F3_OR, rs1_p, OP_REG};
                            default: instr_o = {F7_BASE, rd_p, rs1_p, F3_AND, rs1_p, OP_REG};
                        endcase
                    end
                endcase
                // shamt[5] or the rv64 subw/addw group
                illegal_o = c[12] & (c[11:10] != 2'b10);
            end
            5'b01_101: instr_o = {j_field, 5'd0, OP_JAL};                    // c.j
            5'b01_110, 5'b01_111: begin  // c.beqz / c.bnez
                instr_o = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, rs1_p, 2'b00, c[13],
                           c[11:10], c[4:3], c[12], OP_BRANCH};
            end
            // quadrant 2
            5'b10_000: begin  // c.slli
                instr_o   = {F7_BASE, c[6:2], c[11:7], F3_SLL, c[11:7], OP_IMM};
                illegal_o = c[12];
            end
            5'b10_010: begin  // c.lwsp
                instr_o   = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7],
                             OP_LOAD};
                illegal_o = (c[11:7] == 5'd0);
            end
            5'b10_100: begin
                if (c[6:2] == 5'd0) begin  // c.jr / c.jalr, rd picks the link
                    instr_o   = {12'b0, c[11:7], 3'b000, 4'b0, c[12], OP_JALR};
                    illegal_o = (c[11:7] == 5'd0);   // reserved, or c.ebreak
                end else begin             // c.mv / c.add
                    instr_o = {F7_BASE, c[6:2], c[11:7] & {5{c[12]}}, F3_ADD, c[11:7],
                               OP_REG};
                end
            end
            5'b10_110: instr_o = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9],
                                  2'b00, OP_STORE};                          // c.swsp
            default: illegal_o = is_compressed_o;  // fp loads/stores, reserved
        endcase
        // reserved words expand to opcode zero, so no write, access or redirect
        if (illegal_o) begin
            instr_o = '0;
        end
    end

endmodule

//--- sim/decode_golden.txt
# W: name idx data  (data ffffffff takes an lfsr word)
# D: name pc instr dep en alu flags mem wb_src wb_en rs1_idx rs2_idx imm link rd illegal taken redir
W wr_x1 01 00000100
W wr_x2 02 ffffffff
W wr_x5 05 00001000
W wr_x8 08 00000010
W wr_x9 09 ffffffff
W wr_x10 0a 00000020
W wr_x0 00 deadbeef
W wr_x31 1f 12345678
D rd_x0 00001000 01f06833 0 1 8 0 0 0 1 00 1f 00000000 00001004 10 0 0 00001000
D add 00001004 002081b3 0 1 0 0 0 0 1 01 02 00000000 00001008 03 0 0 00001004
D sub 00001008 40128233 0 1 1 0 0 0 1 05 01 00000000 0000100c 04 0 0 00001008
D sra 0000100c 40945333 0 1 7 0 0 0 1 08 09 00000000 00001010 06 0 0 0000100c
D addi 00001010 ffb08393 0 1 0 4 0 0 1 01 1b fffffffb 00001014 07 0 0 0000100b
D stall_a 00001014 00000013 0 0 0 4 0 0 1 01 1b fffffffb 00001014 07 0 0 0000100b
D xori 00001018 0f02c513 0 1 5 4 0 0 1 05 10 000000f0 0000101c 0a 0 0 00001108
D srai 0000101c 40345593 0 1 7 4 0 0 1 08 03 00000403 00001020 0b 0 0 0000141f
D lw 00001020 0082a603 0 1 0 4 3 1 1 05 08 00000008 00001024 0c 0 0 00001028
D lbu 00001024 fff0c683 0 1 0 4 4 1 1 01 1f ffffffff 00001028 0d 0 0 00001023
D sw 00001028 0020a623 0 1 0 4 8 0 0 01 02 0000000c 0000102c 0c 0 0 00001034
D sh 0000102c fe941e23 0 1 0 4 7 0 0 08 09 fffffffc 00001030 1c 0 0 00001028
D lui 00001030 12345737 0 1 a 4 0 0 1 08 03 12345000 00001034 0e 0 0 12346030
D auipc 00001034 80000797 0 1 0 c 0 0 1 00 00 80000000 00001038 0f 0 0 80001034
D c_addi 00001100 000010fd 0 1 0 4 0 0 1 01 1f ffffffff 00001102 01 0 0 000010ff
D c_lw 00001102 00004144 0 1 0 4 3 1 1 0a 04 00000004 00001104 09 0 0 00001106
D c_sub 00001104 00008c05 0 1 1 0 0 0 1 08 09 00000000 00001106 08 0 0 00001104
D c_mv 00001106 000082aa 0 1 0 0 0 0 1 00 0a 00000000 00001108 05 0 0 00001106
D c_lwsp 00001108 000041a2 0 1 0 4 3 1 1 02 08 00000008 0000110a 03 0 0 00001110
D c_swsp 0000110a 0000c206 0 1 0 4 8 0 0 02 01 00000004 0000110c 04 0 0 0000110e
D c_fld 0000110c 00002000 0 1 0 0 0 0 0 00 00 00000000 0000110e 00 1 0 0000110c
D c_flwsp 0000110e 00006002 0 1 0 0 0 0 0 00 00 00000000 00001110 00 1 0 0000110e
D jal 00002000 010000ef 0 1 0 c 0 2 1 00 10 00000010 00002004 01 0 1 00002010
D beq_back 00002100 fe208ce3 0 1 1 2 0 0 0 01 02 fffffff8 00002104 19 0 1 000020f8
D bne_fwd 00002200 00209463 0 1 1 2 0 0 0 01 02 00000008 00002204 08 0 0 00002208
D jalr_rdy 00002300 00528067 0 1 0 4 0 2 1 05 05 00000005 00002304 00 0 1 00001004
D stall_b 00002304 00000013 0 0 0 4 0 2 1 05 05 00000005 00002304 00 0 1 00001004
D jalr_dep 00002300 00528067 1 1 0 4 0 2 1 05 05 00000005 00002304 00 0 0 00001004
D csrrw 00003000 300110f3 0 1 0 0 0 0 0 02 00 00000000 00003004 01 1 0 00003000
D mul 00003004 023100b3 0 1 0 0 0 0 0 02 03 00000000 00003008 01 1 0 00003004

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    // ==================================================
    // dut signals and clock
    // ==================================================
    logic clk;
    logic resetn;
    logic en_i;
    xlen_t pc_i;
    instr_t instr_i;
    logic rd_wr_en_i;
    reg_idx_t rd_wr_idx_i;
    xlen_t rd_wr_data_i;
    logic rs1_dep_i;
    id_ex_t id_ex_o;
    xlen_t redir_pc_o;
    logic redir_taken_o;

    decode_stage i_dut (.*);

    always #2 clk = ~clk;   // 4 ns period

    // golden records, D fields in file column order
    string rec_tag [64];
    string rec_name [64];
    logic [31:0] rec_f [64][17];
    int n_rec;
    bit golden_loaded;
    xlen_t shadow [NUM_REGS];   // expected register contents
    logic [31:0] exp_v [17];
    xlen_t exp_rs1, exp_rs2;
    logic [15:0] lfsr_state;
    int fd, code, n_checks, n_errors, n_other;
    string tag, name, line;
    logic [31:0] v [17];
    logic [31:0] act_flags;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [31:0] next_random_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_state[15]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return w;
    endfunction

    task automatic compare_field(input string test, input string field,
                                 input logic [31:0] expv, input logic [31:0] actv);
        n_checks++;
        if (expv !== actv) begin
            $display("Error %s %s expected %h actual %h", test, field, expv, actv);
            n_errors++;
        end
    endtask

    // ==================================================
    // golden file reader
    // ==================================================
    task automatic store_record(input string t, input string n);
        if (n_rec >= 64) begin
            $display("too many records in golden file, %s dropped", n);
            n_other++;
            return;
        end
        rec_tag[n_rec] = t;
        rec_name[n_rec] = n;
        for (int k = 0; k < 17; k++) begin
            rec_f[n_rec][k] = v[k];
        end
        n_rec++;
    endtask

    task automatic load_golden();
        fd = $fopen("sim/decode_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/decode_golden.txt, nothing to run");
            n_other++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tag);
            if (code == 1 && tag.substr(0, 0) == "#") begin
                code = $fgets(line, fd);              // column notes
            end else if (code == 1 && tag == "W") begin
                code = $fscanf(fd, " %s %h %h", name, v[0], v[1]);
                if (code != 3) begin
                    $display("short W record %s in golden file", name);
                    n_other++;
                end
                store_record(tag, name);
            end else if (code == 1 && tag == "D") begin
                code = $fscanf(fd, " %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                               v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
                if (code != 18) begin
                    $display("short D record %s in golden file", name);
                    n_other++;
                end
                store_record(tag, name);
            end else if (code == 1) begin
                $display("unknown record tag %s in golden file", tag);
                n_other++;
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // stimulus and checks
    // ==================================================
    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        en_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        rd_wr_en_i = 1'b0;
        rd_wr_idx_i = '0;
        rd_wr_data_i = '0;
        rs1_dep_i = 1'b0;
        lfsr_state = 16'd30961;
        n_rec = 0;
        n_checks = 0;
        n_errors = 0;
        n_other = 0;
        for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;
        load_golden();
        golden_loaded = 1'b1;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        compare_field("reset", "packet", 32'd0, 32'(id_ex_o != '0));
        compare_field("reset", "wb_en", 32'd0, 32'(id_ex_o.ctrl.wb_en));
        compare_field("reset", "taken", 32'd0, 32'(redir_taken_o));
        compare_field("reset", "redir_pc", 32'd0, redir_pc_o);
        for (int i = 0; i < n_rec; i++) begin
            for (int k = 0; k < 17; k++) begin
                v[k] = rec_f[i][k];
            end
            @(posedge clk);
            if (rec_tag[i] == "W") begin
                if (v[1] == 32'hffffffff) v[1] = next_random_word();
                rd_wr_en_i <= 1'b1;
                rd_wr_idx_i <= v[0][4:0];
                rd_wr_data_i <= v[1];
                if (v[0][4:0] != 5'd0) shadow[v[0][4:0]] = v[1];   // x0 stays zero
                @(posedge clk);
                rd_wr_en_i <= 1'b0;
            end else begin
                pc_i <= v[0];
                instr_i <= v[1];
                rs1_dep_i <= v[2][0];
                en_i <= v[3][0];
                if (v[3][0]) begin        // stall keeps the previous expectation
                    for (int k = 0; k < 17; k++) begin
                        exp_v[k] = v[k];
                    end
                    exp_rs1 = shadow[v[9][4:0]];
                    exp_rs2 = shadow[v[10][4:0]];
                end
                @(posedge clk);
                @(negedge clk);
                act_flags = {28'd0, id_ex_o.ctrl.op1_is_pc, id_ex_o.ctrl.op2_is_imm,
                             id_ex_o.ctrl.is_beq_class, id_ex_o.ctrl.is_blt_class};
                compare_field(rec_name[i], "alu_op", exp_v[4], 32'(id_ex_o.ctrl.alu_op));
                compare_field(rec_name[i], "flags", exp_v[5], act_flags);
                compare_field(rec_name[i], "mem_type", exp_v[6], 32'(id_ex_o.ctrl.mem_type));
                compare_field(rec_name[i], "wb_src", exp_v[7], 32'(id_ex_o.ctrl.wb_src));
                compare_field(rec_name[i], "wb_en", exp_v[8], 32'(id_ex_o.ctrl.wb_en));
                compare_field(rec_name[i], "rs1_data", exp_rs1, id_ex_o.rs1_data);
                compare_field(rec_name[i], "rs2_data", exp_rs2, id_ex_o.rs2_data);
                compare_field(rec_name[i], "imm", exp_v[11], id_ex_o.imm);
                compare_field(rec_name[i], "link_pc", exp_v[12], id_ex_o.link_pc);
                compare_field(rec_name[i], "rd_idx", exp_v[13], 32'(id_ex_o.rd_idx));
                compare_field(rec_name[i], "illegal", exp_v[14], 32'(id_ex_o.illegal));
                compare_field(rec_name[i], "taken", exp_v[15], 32'(redir_taken_o));
                if (exp_v[15][0]) begin   // target only matters when taken
                    compare_field(rec_name[i], "redir_pc", exp_v[16], redir_pc_o);
                end
            end
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_errors, n_other);
        if (n_errors == 0 && n_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, two cycles per record plus margin
    initial begin
        wait (golden_loaded);
        #(n_rec * 8 + 200);
        $display("watchdog timeout, record sequence did not complete");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
